// File: verilog/xv_video_pkg.sv
// video side constants, pixel widths and palette word layout

package xv_video_pkg;

    // colour channel and pixel widths
    localparam int CHAN_W    = 4;             // bits per r/g/b channel
    localparam int RGB_W     = 3 * CHAN_W;    // packed r,g,b
    localparam int XRGB_W    = 16;            // one palette word

    // palette geometry
    localparam int PAL_DEPTH = 16;            // entries per playfield palette
    localparam int PAL_IDX_W = 4;             // log2 of PAL_DEPTH

    // pixel in -> rgb out, lookup stage + blend stage
    localparam int PIPE_LAT  = 2;

    // blend mode = {A flag, B alpha}
    localparam int BLEND_W = 3;
    localparam logic [BLEND_W-1:0] BLEND_A         = 3'b0_00;  // B transparent
    localparam logic [BLEND_W-1:0] BLEND_ADD_CLAMP = 3'b0_01;  // additive, saturating
    localparam logic [BLEND_W-1:0] BLEND_AVERAGE   = 3'b0_10;  // 50/50 mix
    localparam logic [BLEND_W-1:0] BLEND_B         = 3'b0_11;  // B opaque
    localparam logic [BLEND_W-1:0] BLEND_AND       = 3'b1_00;  // logical and
    localparam logic [BLEND_W-1:0] BLEND_SUB_CLAMP = 3'b1_01;  // subtractive, floor 0
    localparam logic [BLEND_W-1:0] BLEND_OR        = 3'b1_10;  // logical or
    localparam logic [BLEND_W-1:0] BLEND_ADD_WRAP  = 3'b1_11;  // offset, mod 16

    // palette word, read differently for playfield A and playfield B
    typedef union packed {
        struct packed {
            logic             flag;   // selects logic blend group
            logic [2:0]       spare;
            logic [RGB_W-1:0] rgb;    // r[11:8] g[7:4] b[3:0]
        } a_view;
        struct packed {
            logic [1:0]       alpha;  // blend amount of B over A
            logic [1:0]       spare;
            logic [RGB_W-1:0] rgb;
        } b_view;
    } xrgb_t;

endpackage

// File: verilog/xv_bus_pkg.sv
// cpu register port numbering and interrupt layout

package xv_bus_pkg;

    // bus geometry
    localparam int REG_NUM_W  = 4;    // bus_reg_num_i width
    localparam int BUS_DATA_W = 8;    // byte wide data bus
    localparam int BUS_WORD_W = 16;   // even+odd byte pair

    // register numbers
    localparam logic [REG_NUM_W-1:0] REG_COLOR_ADDR  = 4'd0;  // [4] pal B, [3:0] index
    localparam logic [REG_NUM_W-1:0] REG_COLOR_DATA  = 4'd1;  // palette word, auto inc
    localparam logic [REG_NUM_W-1:0] REG_INTR_MASK   = 4'd2;  // enable per intr bit
    localparam logic [REG_NUM_W-1:0] REG_INTR_CLEAR  = 4'd3;  // write 1 to clear
    localparam logic [REG_NUM_W-1:0] REG_INTR_FORCE  = 4'd4;  // write 1 to raise
    localparam logic [REG_NUM_W-1:0] REG_INTR_STATUS = 4'd5;  // pending bits, read only

    // palette address fields inside COLOR_ADDR
    localparam int COLOR_ADDR_SEL_BIT = 4;

    // interrupt sources
    localparam int INTR_W     = 4;    // number of interrupt bits
    localparam int INTR_VSYNC = 0;    // vsync rising edge source

endpackage

// File: verilog/bus_regs.sv
`default_nettype none
`timescale 1ns/1ns

// byte wide cpu port, turns even/odd byte pairs into register words
module bus_regs (
    input  wire logic                                clk,
    input  wire logic                                reset_i,
    input  wire logic                                bus_cs_n_i,     // one clock low per access
    input  wire logic                                bus_rd_nwr_i,   // 1 = read
    input  wire logic [xv_bus_pkg::REG_NUM_W-1:0]    bus_reg_num_i,
    input  wire logic                                bus_bytesel_i,  // 0 = even (high) byte
    input  wire logic [xv_bus_pkg::BUS_DATA_W-1:0]   bus_data_i,
    output logic      [xv_bus_pkg::BUS_DATA_W-1:0]   bus_data_o,
    output logic                                     pal_wr_o,       // one cycle write pulse
    output logic                                     pal_sel_o,      // 1 = palette B
    output logic      [xv_video_pkg::PAL_IDX_W-1:0]  pal_idx_o,
    output logic      [xv_video_pkg::XRGB_W-1:0]     pal_data_o,
    output logic      [xv_bus_pkg::INTR_W-1:0]       intr_mask_o,
    output logic      [xv_bus_pkg::INTR_W-1:0]       intr_clear_o,   // pulse
    output logic      [xv_bus_pkg::INTR_W-1:0]       intr_force_o,   // pulse
    input  wire logic [xv_bus_pkg::INTR_W-1:0]       intr_status_i
);

logic [xv_bus_pkg::BUS_DATA_W-1:0]  hi_byte;       // latched even byte
logic [xv_bus_pkg::BUS_WORD_W-1:0]  wr_word;       // full word on odd write
logic [xv_bus_pkg::BUS_WORD_W-1:0]  rd_word;       // selected register for reads
logic                               wr_even;
logic                               wr_commit;
logic                               rd_strobe;
logic                               addr_sel;      // current palette select
logic [xv_video_pkg::PAL_IDX_W-1:0] addr_idx;      // current palette index

assign wr_even   = !bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i;
assign wr_commit = !bus_cs_n_i && !bus_rd_nwr_i &&  bus_bytesel_i;
assign rd_strobe = !bus_cs_n_i &&  bus_rd_nwr_i;
assign wr_word   = {hi_byte, bus_data_i};          // odd byte completes the word

// readable registers, others read as zero
always_comb begin
    rd_word = '0;
    case (bus_reg_num_i)
        xv_bus_pkg::REG_COLOR_ADDR: begin
            rd_word[xv_bus_pkg::COLOR_ADDR_SEL_BIT]    = addr_sel;
            rd_word[xv_video_pkg::PAL_IDX_W-1:0]       = addr_idx;
        end
        xv_bus_pkg::REG_INTR_MASK:   rd_word[xv_bus_pkg::INTR_W-1:0] = intr_mask_o;
        xv_bus_pkg::REG_INTR_STATUS: rd_word[xv_bus_pkg::INTR_W-1:0] = intr_status_i;
        default:                     rd_word = '0;
    endcase
end

// high byte latch and palette write payload
always_ff @(posedge clk) begin
    if (wr_even) begin
        hi_byte <= bus_data_i;
    end
    if (wr_commit && bus_reg_num_i == xv_bus_pkg::REG_COLOR_DATA) begin
        pal_sel_o  <= addr_sel;                    // address before increment
        pal_idx_o  <= addr_idx;
        pal_data_o <= wr_word;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        pal_wr_o     <= 1'b0;
        intr_clear_o <= '0;
        intr_force_o <= '0;
        intr_mask_o  <= '0;
        addr_sel     <= 1'b0;
        addr_idx     <= '0;
        bus_data_o   <= '0;
    end else begin
        // pulses drop after one cycle
        pal_wr_o     <= 1'b0;
        intr_clear_o <= '0;
        intr_force_o <= '0;

        if (wr_commit) begin
            case (bus_reg_num_i)
                xv_bus_pkg::REG_COLOR_ADDR: begin
                    addr_sel <= wr_word[xv_bus_pkg::COLOR_ADDR_SEL_BIT];
                    addr_idx <= wr_word[xv_video_pkg::PAL_IDX_W-1:0];
                end
                xv_bus_pkg::REG_COLOR_DATA: begin
                    pal_wr_o <= 1'b1;
                    addr_idx <= addr_idx + 1'b1;   // wraps inside the palette
                end
                xv_bus_pkg::REG_INTR_MASK:  intr_mask_o  <= wr_word[xv_bus_pkg::INTR_W-1:0];
                xv_bus_pkg::REG_INTR_CLEAR: intr_clear_o <= wr_word[xv_bus_pkg::INTR_W-1:0];
                xv_bus_pkg::REG_INTR_FORCE: intr_force_o <= wr_word[xv_bus_pkg::INTR_W-1:0];
                default: ;                         // status is read only
            endcase
        end

        // read byte held until next read
        if (rd_strobe) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
    end
end

endmodule
`default_nettype wire

// File: verilog/color_lookup.sv
`default_nettype none
`timescale 1ns/1ns

// two palette rams, one shared write port, parallel read of A and B
module color_lookup (
    input  wire logic                                clk,
    input  wire logic                                reset_i,
    input  wire logic                                pal_wr_i,
    input  wire logic                                pal_sel_i,   // 0 = A, 1 = B
    input  wire logic [xv_video_pkg::PAL_IDX_W-1:0]  pal_idx_i,
    input  wire logic [xv_video_pkg::XRGB_W-1:0]     pal_data_i,
    input  wire logic [xv_video_pkg::PAL_IDX_W-1:0]  idx_a_i,     // playfield A index
    input  wire logic [xv_video_pkg::PAL_IDX_W-1:0]  idx_b_i,     // playfield B index
    input  wire logic                                de_i,
    input  wire logic                                hsync_i,
    input  wire logic                                vsync_i,
    output xv_video_pkg::xrgb_t                      color_a_o,
    output xv_video_pkg::xrgb_t                      color_b_o,
    output logic                                     de_o,
    output logic                                     hsync_o,
    output logic                                     vsync_o
);

xv_video_pkg::xrgb_t pal_a [xv_video_pkg::PAL_DEPTH];   // playfield A colours
xv_video_pkg::xrgb_t pal_b [xv_video_pkg::PAL_DEPTH];   // playfield B colours

// write then read, read returns old word on same-edge collision
always_ff @(posedge clk) begin
    if (pal_wr_i && !pal_sel_i) begin
        pal_a[pal_idx_i] <= pal_data_i;
    end
    color_a_o <= pal_a[idx_a_i];
end

always_ff @(posedge clk) begin
    if (pal_wr_i && pal_sel_i) begin
        pal_b[pal_idx_i] <= pal_data_i;
    end
    color_b_o <= pal_b[idx_b_i];
end

// timing signals follow the ram latency
always_ff @(posedge clk) begin
    if (reset_i) begin
        de_o    <= 1'b0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
    end else begin
        de_o    <= de_i;
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
    end
end

endmodule
`default_nettype wire

// File: verilog/playfield_blend.sv
`default_nettype none
`timescale 1ns/1ns

// mixes playfield B over playfield A, registers rgb and syncs
module playfield_blend (
    input  wire logic                             clk,
    input  wire logic                             reset_i,
    input  wire xv_video_pkg::xrgb_t              color_a_i,   // bottom playfield
    input  wire xv_video_pkg::xrgb_t              color_b_i,   // top playfield
    input  wire logic                             de_i,
    input  wire logic                             hsync_i,
    input  wire logic                             vsync_i,
    output logic      [xv_video_pkg::CHAN_W-1:0]  red_o,
    output logic      [xv_video_pkg::CHAN_W-1:0]  green_o,
    output logic      [xv_video_pkg::CHAN_W-1:0]  blue_o,
    output logic                                  hsync_o,
    output logic                                  vsync_o,
    output logic                                  dv_de_o
);

// one channel of one mode
function automatic logic [xv_video_pkg::CHAN_W-1:0] blend_chan(
    input logic [xv_video_pkg::BLEND_W-1:0] mode,
    input logic [xv_video_pkg::CHAN_W-1:0]  a,
    input logic [xv_video_pkg::CHAN_W-1:0]  b
);
    logic [xv_video_pkg::CHAN_W:0]   sum;    // carry in msb
    logic [xv_video_pkg::CHAN_W:0]   diff;   // borrow in msb
    logic [xv_video_pkg::CHAN_W-1:0] res;
    sum  = {1'b0, a} + {1'b0, b};
    diff = {1'b0, a} - {1'b0, b};
    case (mode)
        xv_video_pkg::BLEND_A:         res = a;
        xv_video_pkg::BLEND_ADD_CLAMP: res = sum[xv_video_pkg::CHAN_W] ? '1 : sum[3:0];
        xv_video_pkg::BLEND_AVERAGE:   res = sum[xv_video_pkg::CHAN_W:1];   // floor of half
        xv_video_pkg::BLEND_B:         res = b;
        xv_video_pkg::BLEND_AND:       res = a & b;
        xv_video_pkg::BLEND_SUB_CLAMP: res = diff[xv_video_pkg::CHAN_W] ? '0 : diff[3:0];
        xv_video_pkg::BLEND_OR:        res = a | b;
        default:                       res = sum[3:0];                      // add modulo 16
    endcase
    return res;
endfunction

logic [xv_video_pkg::BLEND_W-1:0] mode;
logic [xv_video_pkg::RGB_W-1:0]   rgb_a;
logic [xv_video_pkg::RGB_W-1:0]   rgb_b;

assign mode  = {color_a_i.a_view.flag, color_b_i.b_view.alpha};  // A group, B amount
assign rgb_a = color_a_i.a_view.rgb;
assign rgb_b = color_b_i.b_view.rgb;

always_ff @(posedge clk) begin
    if (reset_i) begin
        red_o   <= '0;
        green_o <= '0;
        blue_o  <= '0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
    end else begin
        if (de_i) begin
            red_o   <= blend_chan(mode, rgb_a[11:8], rgb_b[11:8]);
            green_o <= blend_chan(mode, rgb_a[7:4],  rgb_b[7:4]);
            blue_o  <= blend_chan(mode, rgb_a[3:0],  rgb_b[3:0]);
        end else begin
            red_o   <= '0;                         // blanking is black
            green_o <= '0;
            blue_o  <= '0;
        end
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
        dv_de_o <= de_i;
    end
end

endmodule
`default_nettype wire

// File: verilog/intr_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

// interrupt pending status and cpu interrupt pulse
module intr_ctrl (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           vsync_i,       // raw pixel vsync
    input  wire logic [xv_bus_pkg::INTR_W-1:0]  intr_mask_i,
    input  wire logic [xv_bus_pkg::INTR_W-1:0]  intr_clear_i,
    input  wire logic [xv_bus_pkg::INTR_W-1:0]  intr_force_i,
    output logic      [xv_bus_pkg::INTR_W-1:0]  intr_status_o,
    output logic                                bus_intr_o     // one cycle strobe
);

logic                          vsync_1;       // sampled vsync
logic                          vsync_2;       // previous sample
logic [xv_bus_pkg::INTR_W-1:0] intr_signal;   // new events this cycle

// vsync edge lines up with force pulse timing
always_comb begin
    intr_signal = intr_force_i;
    intr_signal[xv_bus_pkg::INTR_VSYNC] = intr_force_i[xv_bus_pkg::INTR_VSYNC]
                                          | (vsync_1 & ~vsync_2);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vsync_1       <= 1'b0;
        vsync_2       <= 1'b0;
        intr_status_o <= '0;
        bus_intr_o    <= 1'b0;
    end else begin
        vsync_1       <= vsync_i;
        vsync_2       <= vsync_1;
        bus_intr_o    <= |(intr_signal & intr_mask_i & ~intr_status_o);  // only if not pending
        intr_status_o <= (intr_status_o | intr_signal) & ~intr_clear_i;
    end
end

endmodule
`default_nettype wire

// File: verilog/xv_compositor.sv
`default_nettype none
`timescale 1ns/1ns

// two playfield compositor with cpu register port
module xv_compositor (
    input  wire logic                                clk,
    input  wire logic                                reset_i,
    input  wire logic                                bus_cs_n_i,
    input  wire logic                                bus_rd_nwr_i,
    input  wire logic [xv_bus_pkg::REG_NUM_W-1:0]    bus_reg_num_i,
    input  wire logic                                bus_bytesel_i,
    input  wire logic [xv_bus_pkg::BUS_DATA_W-1:0]   bus_data_i,
    output logic      [xv_bus_pkg::BUS_DATA_W-1:0]   bus_data_o,
    input  wire logic [xv_video_pkg::PAL_IDX_W-1:0]  idx_a_i,
    input  wire logic [xv_video_pkg::PAL_IDX_W-1:0]  idx_b_i,
    input  wire logic                                de_i,
    input  wire logic                                hsync_i,
    input  wire logic                                vsync_i,
    output logic      [xv_video_pkg::CHAN_W-1:0]     red_o,
    output logic      [xv_video_pkg::CHAN_W-1:0]     green_o,
    output logic      [xv_video_pkg::CHAN_W-1:0]     blue_o,
    output logic                                     hsync_o,
    output logic                                     vsync_o,
    output logic                                     dv_de_o,
    output logic                                     bus_intr_o
);

// palette write port
logic                               pal_wr;
logic                               pal_sel;
logic [xv_video_pkg::PAL_IDX_W-1:0] pal_idx;
logic [xv_video_pkg::XRGB_W-1:0]    pal_data;
// interrupt controls
logic [xv_bus_pkg::INTR_W-1:0]      intr_mask;
logic [xv_bus_pkg::INTR_W-1:0]      intr_clear;
logic [xv_bus_pkg::INTR_W-1:0]      intr_force;
logic [xv_bus_pkg::INTR_W-1:0]      intr_status;
// lookup stage -> blend stage
xv_video_pkg::xrgb_t                color_a;
xv_video_pkg::xrgb_t                color_b;
logic                               lk_de;
logic                               lk_hsync;
logic                               lk_vsync;

bus_regs u_bus_regs (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .pal_wr_o(pal_wr), .pal_sel_o(pal_sel), .pal_idx_o(pal_idx), .pal_data_o(pal_data),
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear), .intr_force_o(intr_force),
    .intr_status_i(intr_status)
);

color_lookup u_color_lookup (
    .clk(clk), .reset_i(reset_i),
    .pal_wr_i(pal_wr), .pal_sel_i(pal_sel), .pal_idx_i(pal_idx), .pal_data_i(pal_data),
    .idx_a_i(idx_a_i), .idx_b_i(idx_b_i),
    .de_i(de_i), .hsync_i(hsync_i), .vsync_i(vsync_i),
    .color_a_o(color_a), .color_b_o(color_b),
    .de_o(lk_de), .hsync_o(lk_hsync), .vsync_o(lk_vsync)
);

playfield_blend u_playfield_blend (
    .clk(clk), .reset_i(reset_i),
    .color_a_i(color_a), .color_b_i(color_b),
    .de_i(lk_de), .hsync_i(lk_hsync), .vsync_i(lk_vsync),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

// raw vsync, edge detect inside
intr_ctrl u_intr_ctrl (
    .clk(clk), .reset_i(reset_i),
    .vsync_i(vsync_i),
    .intr_mask_i(intr_mask), .intr_clear_i(intr_clear), .intr_force_i(intr_force),
    .intr_status_o(intr_status), .bus_intr_o(bus_intr_o)
);

endmodule
`default_nettype wire

// File: dv/compositor_props.sv
`timescale 1ns/1ns

// concurrent checks of the compositor ports against the reference model
module compositor_props (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [11:0] rgb_i,          // {red, green, blue} from the DUT
    input  logic        hsync_i,
    input  logic        vsync_i,
    input  logic        de_i,
    input  logic        intr_i,
    input  logic [11:0] exp_rgb_i,      // model pixel, same latency
    input  logic        exp_hsync_i,
    input  logic        exp_vsync_i,
    input  logic        exp_de_i,
    input  logic        exp_intr_i,
    output logic        fail_o          // rises on first mismatch
);

initial fail_o = 1'b0;

task automatic flag_error(input string name, input logic [11:0] expv, input logic [11:0] actv);
    $display("FAILED %s expected %h actual %h", name, expv, actv);
    fail_o = 1'b1;
endtask

// blended colour against the model
rgb_match: assert property (@(posedge clk) disable iff (reset_i) rgb_i == exp_rgb_i)
    else flag_error("pixel rgb", $sampled(exp_rgb_i), $sampled(rgb_i));

// blanking region is black
blank_black: assert property (@(posedge clk) disable iff (reset_i) !de_i |-> rgb_i == 12'h000)
    else flag_error("blanking rgb", 12'h000, $sampled(rgb_i));

// timing signals delayed by the pipeline
hsync_match: assert property (@(posedge clk) disable iff (reset_i) hsync_i == exp_hsync_i)
    else flag_error("hsync_o", $sampled(exp_hsync_i), $sampled(hsync_i));

vsync_match: assert property (@(posedge clk) disable iff (reset_i) vsync_i == exp_vsync_i)
    else flag_error("vsync_o", $sampled(exp_vsync_i), $sampled(vsync_i));

de_match: assert property (@(posedge clk) disable iff (reset_i) de_i == exp_de_i)
    else flag_error("dv_de_o", $sampled(exp_de_i), $sampled(de_i));

// one cycle pulse, exact cycle, no extra pulses
intr_match: assert property (@(posedge clk) disable iff (reset_i) intr_i == exp_intr_i)
    else flag_error("bus_intr_o", $sampled(exp_intr_i), $sampled(intr_i));

endmodule

// File: dv/tb_compositor.sv
`timescale 1ns/1ns

module tb_compositor;

logic       clk;
logic       reset_i;
logic       bus_cs_n_i;
logic       bus_rd_nwr_i;
logic [3:0] bus_reg_num_i;
logic       bus_bytesel_i;
logic [7:0] bus_data_i;
logic [7:0] bus_data_o;
logic [3:0] idx_a_i;
logic [3:0] idx_b_i;
logic       de_i;
logic       hsync_i;
logic       vsync_i;
logic [3:0] red_o;
logic [3:0] green_o;
logic [3:0] blue_o;
logic       hsync_o;
logic       vsync_o;
logic       dv_de_o;
logic       bus_intr_o;
logic       prop_fail;
logic [31:0] lcg_state;

// reference model state
xv_video_pkg::xrgb_t ref_pal_a [xv_video_pkg::PAL_DEPTH];
xv_video_pkg::xrgb_t ref_pal_b [xv_video_pkg::PAL_DEPTH];
xv_video_pkg::xrgb_t look_a;
xv_video_pkg::xrgb_t look_b;
logic        look_de, look_hs, look_vs;            // stage 1 timing
logic [7:0]  ref_hi;                               // even byte latch
logic        ref_sel;
logic [3:0]  ref_idx;
logic        wr_pend;                              // palette write lands next edge
logic        wr_pend_sel;
logic [3:0]  wr_pend_idx;
logic [15:0] wr_pend_data;
logic [3:0]  ref_mask, ref_status, ev_d, clr_d;
logic        vs_prev;
logic [11:0] exp_rgb;
logic        exp_hs, exp_vs, exp_de, exp_intr;

xv_compositor DUT (.*);

compositor_props u_props (
    .clk(clk), .reset_i(reset_i),
    .rgb_i({red_o, green_o, blue_o}), .hsync_i(hsync_o), .vsync_i(vsync_o),
    .de_i(dv_de_o), .intr_i(bus_intr_o),
    .exp_rgb_i(exp_rgb), .exp_hsync_i(exp_hs), .exp_vsync_i(exp_vs),
    .exp_de_i(exp_de), .exp_intr_i(exp_intr), .fail_o(prop_fail)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                        // 40 ns period
end

task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic report_mismatch(input string name, input logic [15:0] expv,
                               input logic [15:0] actv);
    $display("FAILED %s expected %h actual %h", name, expv, actv);
    fail_run();
endtask

always @(posedge prop_fail) fail_run();

function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];                       // upper bits, better period
endfunction

// one channel per blend rule
function automatic logic [3:0] mix_channel(input logic [2:0] mode, input int a, input int b);
    int r;
    case (mode)
        xv_video_pkg::BLEND_A:         r = a;
        xv_video_pkg::BLEND_ADD_CLAMP: r = (a + b > 15) ? 15 : a + b;
        xv_video_pkg::BLEND_AVERAGE:   r = (a + b) / 2;
        xv_video_pkg::BLEND_B:         r = b;
        xv_video_pkg::BLEND_AND:       r = a & b;
        xv_video_pkg::BLEND_SUB_CLAMP: r = (a > b) ? a - b : 0;
        xv_video_pkg::BLEND_OR:        r = a | b;
        default:                       r = (a + b) % 16;
    endcase
    return r[3:0];
endfunction

function automatic logic [11:0] blend_pixel(input xv_video_pkg::xrgb_t ca,
                                            input xv_video_pkg::xrgb_t cb);
    logic [2:0]  mode;
    logic [11:0] res;
    mode = {ca.a_view.flag, cb.b_view.alpha};
    for (int ch = 0; ch < 3; ch++) begin
        res[ch*4 +: 4] = mix_channel(mode, ca.a_view.rgb[ch*4 +: 4], cb.b_view.rgb[ch*4 +: 4]);
    end
    return res;
endfunction

// model sees the bus and pixel inputs as the DUT samples them
always @(posedge clk) begin
    logic [15:0] word;
    logic [3:0]  ev_now;
    logic [3:0]  clr_now;
    word = {ref_hi, bus_data_i};
    ev_now = '0;
    ev_now[xv_bus_pkg::INTR_VSYNC] = vsync_i & ~vs_prev;
    clr_now = '0;
    if (reset_i) begin
        {ref_sel, ref_idx, wr_pend, look_de, look_hs, look_vs} <= '0;
        {exp_rgb, exp_hs, exp_vs, exp_de, exp_intr} <= '0;
        {ref_mask, ref_status, ev_d, clr_d, vs_prev} <= '0;
    end else begin
        wr_pend <= 1'b0;
        if (!bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i) begin
            ref_hi <= bus_data_i;
        end else if (!bus_cs_n_i && !bus_rd_nwr_i) begin
            case (bus_reg_num_i)
                xv_bus_pkg::REG_COLOR_ADDR: begin
                    ref_sel <= word[4];
                    ref_idx <= word[3:0];
                end
                xv_bus_pkg::REG_COLOR_DATA: begin
                    wr_pend      <= 1'b1;
                    wr_pend_sel  <= ref_sel;
                    wr_pend_idx  <= ref_idx;
                    wr_pend_data <= word;
                    ref_idx      <= ref_idx + 4'd1;    // wraps in palette
                end
                xv_bus_pkg::REG_INTR_MASK:  ref_mask <= word[3:0];
                xv_bus_pkg::REG_INTR_CLEAR: clr_now = word[3:0];
                xv_bus_pkg::REG_INTR_FORCE: ev_now = ev_now | word[3:0];
                default: ;
            endcase
        end
        if (wr_pend && wr_pend_sel) ref_pal_b[wr_pend_idx] <= wr_pend_data;
        if (wr_pend && !wr_pend_sel) ref_pal_a[wr_pend_idx] <= wr_pend_data;
        look_a  <= ref_pal_a[idx_a_i];             // old word on same edge
        look_b  <= ref_pal_b[idx_b_i];
        look_de <= de_i;
        look_hs <= hsync_i;
        look_vs <= vsync_i;
        exp_rgb <= look_de ? blend_pixel(look_a, look_b) : 12'h000;
        exp_de  <= look_de;
        exp_hs  <= look_hs;
        exp_vs  <= look_vs;
        exp_intr   <= |(ev_d & ref_mask & ~ref_status);   // new and enabled only
        ref_status <= (ref_status | ev_d) & ~clr_d;
        ev_d    <= ev_now;
        clr_d   <= clr_now;
        vs_prev <= vsync_i;
    end
end

// even byte, gap, odd byte, gap
task automatic bus_write(input logic [3:0] reg_num, input logic [15:0] word);
    @(posedge clk);
    bus_cs_n_i    <= 1'b0;
    bus_rd_nwr_i  <= 1'b0;
    bus_reg_num_i <= reg_num;
    bus_bytesel_i <= 1'b0;
    bus_data_i    <= word[15:8];
    @(posedge clk);
    bus_cs_n_i    <= 1'b1;
    @(posedge clk);
    bus_cs_n_i    <= 1'b0;
    bus_bytesel_i <= 1'b1;
    bus_data_i    <= word[7:0];
    @(posedge clk);
    bus_cs_n_i    <= 1'b1;
endtask

task automatic read_status(output logic [7:0] actv);
    logic [3:0] model;
    @(posedge clk);
    bus_cs_n_i    <= 1'b0;
    bus_rd_nwr_i  <= 1'b1;
    bus_reg_num_i <= xv_bus_pkg::REG_INTR_STATUS;
    bus_bytesel_i <= 1'b1;                         // odd byte holds the bits
    @(posedge clk);
    bus_cs_n_i <= 1'b1;
    model = ref_status;                            // what the DUT samples here
    @(posedge clk);
    actv = bus_data_o;
    assert (actv == {4'h0, model}) else report_mismatch("status read", model, actv);
endtask

task automatic wait_intr(input string name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!bus_intr_o && cycles < 8) begin
        @(posedge clk);
        cycles++;
    end
    if (!bus_intr_o) begin
        $display("timeout: %s never raised bus_intr_o", name);
        fail_run();
    end
endtask

task automatic fill_palettes();
    logic [15:0] word;
    for (int sel = 0; sel < 2; sel++) begin
        bus_write(xv_bus_pkg::REG_COLOR_ADDR, {11'd0, sel[0], 4'd0});
        for (int i = 0; i < xv_video_pkg::PAL_DEPTH; i++) begin
            word = lcg_next();
            // mode bits tied to index so every combination is reachable
            if (sel == 0) begin
                word[15] = i[0];
            end else begin
                word[15:14] = i[1:0];
            end
            bus_write(xv_bus_pkg::REG_COLOR_DATA, word);
        end
    end
endtask

task automatic stream_pixels(input int count, input bit ctrl_random, input bit burst_b);
    logic [15:0] rnd;
    repeat (count) begin
        @(posedge clk);
        rnd = lcg_next();
        idx_a_i <= rnd[3:0];
        idx_b_i <= burst_b ? 4'd14 + rnd[5:4] : rnd[7:4];   // 14,15,0,1 in burst
        de_i    <= ctrl_random ? rnd[8] : 1'b1;
        hsync_i <= ctrl_random & rnd[9];
        vsync_i <= ctrl_random & rnd[10];
    end
    @(posedge clk);
    de_i    <= 1'b0;
    hsync_i <= 1'b0;
    vsync_i <= 1'b0;
    repeat (xv_video_pkg::PIPE_LAT + 1) @(posedge clk);     // drain pipeline
endtask

initial begin
    logic [7:0] actv;
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = '0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;
    idx_a_i       = '0;
    idx_b_i       = '0;
    de_i          = 1'b0;
    hsync_i       = 1'b0;
    vsync_i       = 1'b0;
    lcg_state     = 32'd4;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;

    fill_palettes();                               // all modes, de high
    stream_pixels(200, 1'b0, 1'b0);
    stream_pixels(100, 1'b1, 1'b0);                // blanking and syncs

    bus_write(xv_bus_pkg::REG_COLOR_ADDR, 16'h001E);       // palette B, index 14
    repeat (4) bus_write(xv_bus_pkg::REG_COLOR_DATA, lcg_next());
    stream_pixels(64, 1'b0, 1'b1);

    bus_write(xv_bus_pkg::REG_INTR_MASK, 16'h0005);        // bits 0 and 2
    bus_write(xv_bus_pkg::REG_INTR_FORCE, 16'h0006);
    wait_intr("force bits 1 and 2");
    bus_write(xv_bus_pkg::REG_INTR_FORCE, 16'h0004);       // already pending
    repeat (4) @(posedge clk);

    read_status(actv);
    bus_write(xv_bus_pkg::REG_INTR_CLEAR, 16'h000F);
    read_status(actv);
    assert (actv == 8'h00) else report_mismatch("status after clear", 16'h0000, {8'h00, actv});
    @(posedge clk);
    vsync_i <= 1'b1;
    wait_intr("vsync rising edge");
    read_status(actv);
    assert (actv[xv_bus_pkg::INTR_VSYNC])
        else report_mismatch("vsync status bit", 16'h0001, {15'h0000, actv[0]});
    repeat (4) @(posedge clk);

    if (prop_fail) begin
        fail_run();
    end else begin
        $display("SIMULATION PASSED");
        $finish;
    end
end

endmodule

// File: project.f
verilog/xv_video_pkg.sv
verilog/xv_bus_pkg.sv
verilog/bus_regs.sv
verilog/color_lookup.sv
verilog/playfield_blend.sv
verilog/intr_ctrl.sv
verilog/xv_compositor.sv
dv/compositor_props.sv
dv/tb_compositor.sv
